/* design/bus_controller.sv */
/*
 * Shared bus controller
 * Round-robin arbiter, snoop broadcast, 256-word memory and coherence counters
 */
`timescale 1ns/1ps

module bus_controller (
    input  logic                             CLK,
    input  logic                             nRST,
    snoop_bus_if.ctrl                        port0,
    snoop_bus_if.ctrl                        port1,
    output logic [cache_geom_pkg::CNT_W-1:0] fills_exclusive,
    output logic [cache_geom_pkg::CNT_W-1:0] fills_shared,
    output logic [cache_geom_pkg::CNT_W-1:0] snoop_invalidations,
    output logic [cache_geom_pkg::CNT_W-1:0] snoop_downgrades,
    output logic [cache_geom_pkg::CNT_W-1:0] writebacks
);

    enum logic [1:0] {IDLE, SNOOP, DONE} state_q;

    logic [1:0] gnt_q;                  // One-hot, bit n for port n
    logic [1:0] gnt_d;
    logic       last_q;                 // Set when port1 won last
    logic       pick0;

    logic [cache_geom_pkg::DATA_W-1:0]    mem [cache_geom_pkg::MEM_WORDS];
    logic [cache_geom_pkg::MEM_WORDS-1:0] mem_valid;  // Unwritten words read as zero
    logic [cache_geom_pkg::DATA_W-1:0]    mem_word;
    logic [cache_geom_pkg::DATA_W-1:0]    rdata_q;
    logic                                 exclusive_q;

    coherence_pkg::bus_cmd_t              g_cmd;
    cache_geom_pkg::cache_addr_u          g_addr;
    logic [cache_geom_pkg::DATA_W-1:0]    g_wdata;
    logic                                 snp_on;
    logic                                 snp_hit;
    logic                                 snp_dirty;
    logic [cache_geom_pkg::DATA_W-1:0]    snp_data;

    assign pick0 = port0.req && (!port1.req || last_q);
    assign gnt_d = {port1.req && !pick0, pick0};

    // Granted request and the other port's snoop reply
    assign g_cmd   = gnt_q[1] ? port1.cmd   : port0.cmd;
    assign g_addr  = gnt_q[1] ? port1.addr  : port0.addr;
    assign g_wdata = gnt_q[1] ? port1.wdata : port0.wdata;

    assign snp_on    = state_q == SNOOP && g_cmd != coherence_pkg::BUS_WB;
    assign snp_hit   = snp_on && (gnt_q[1] ? port0.snoop_hit   : port1.snoop_hit);
    assign snp_dirty = snp_on && (gnt_q[1] ? port0.snoop_dirty : port1.snoop_dirty);
    assign snp_data  = gnt_q[1] ? port0.snoop_data : port1.snoop_data;

    assign port0.snoop_valid = snp_on && gnt_q[1];
    assign port1.snoop_valid = snp_on && gnt_q[0];
    assign port0.snoop_addr  = port1.addr;
    assign port1.snoop_addr  = port0.addr;
    assign port0.snoop_inv   = port1.cmd == coherence_pkg::BUS_RDX;
    assign port1.snoop_inv   = port0.cmd == coherence_pkg::BUS_RDX;

    assign port0.done      = state_q == DONE && gnt_q[0];
    assign port1.done      = state_q == DONE && gnt_q[1];
    assign port0.rdata     = rdata_q;
    assign port1.rdata     = rdata_q;
    assign port0.exclusive = exclusive_q;
    assign port1.exclusive = exclusive_q;

    assign mem_word = mem_valid[g_addr.raw] ? mem[g_addr.raw] : '0;

    always_ff @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            state_q             <= IDLE;
            gnt_q               <= 2'b00;
            last_q              <= 1'b1;    // Port0 first after reset
            mem_valid           <= '0;
            fills_exclusive     <= '0;
            fills_shared        <= '0;
            snoop_invalidations <= '0;
            snoop_downgrades    <= '0;
            writebacks          <= '0;
        end else begin
            case (state_q)
                IDLE: begin
                    if (|gnt_d) begin
                        gnt_q   <= gnt_d;
                        last_q  <= gnt_d[1];
                        state_q <= SNOOP;
                    end
                end
                SNOOP: begin
                    state_q <= DONE;
                    if (snp_dirty || g_cmd == coherence_pkg::BUS_WB) begin
                        mem_valid[g_addr.raw] <= 1'b1;
                    end
                    case (g_cmd)
                        coherence_pkg::BUS_RD: begin
                            if (snp_hit) begin
                                fills_shared     <= fills_shared + 1'b1;
                                snoop_downgrades <= snoop_downgrades + 1'b1;
                            end else begin
                                fills_exclusive  <= fills_exclusive + 1'b1;
                            end
                        end
                        coherence_pkg::BUS_RDX: begin
                            if (snp_hit) begin
                                snoop_invalidations <= snoop_invalidations + 1'b1;
                            end
                        end
                        default: writebacks <= writebacks + 1'b1;
                    endcase
                end
                default: begin
                    state_q <= IDLE;
                    gnt_q   <= 2'b00;
                end
            endcase
        end
    end

    // Memory and returned data
    always_ff @(posedge CLK) begin
        if (state_q == SNOOP) begin
            rdata_q     <= snp_dirty ? snp_data : mem_word;
            exclusive_q <= g_cmd == coherence_pkg::BUS_RD && !snp_hit;
            if (snp_dirty) begin
                mem[g_addr.raw] <= snp_data;
            end
            if (g_cmd == coherence_pkg::BUS_WB) begin
                mem[g_addr.raw] <= g_wdata;
            end
        end
    end

    // The granted unit keeps its request up for the whole transaction
    a_grant_has_req: assert property (@(posedge CLK) disable iff (!nRST)
        state_q != IDLE |-> (gnt_q[0] && port0.req) || (gnt_q[1] && port1.req))
        else $error("granted port has no request");

    a_req_stable: assert property (@(posedge CLK) disable iff (!nRST)
        state_q == SNOOP |=> $stable(g_cmd) && $stable(g_addr.raw))
        else $error("granted command changed during the transaction");

endmodule

/* design/cache_geom_pkg.sv */
/*
 * Cache and memory geometry
 * Word address split into tag and set index, plus counter width
 */
package cache_geom_pkg;

    localparam int ADDR_W    = 8;
    localparam int DATA_W    = 32;
    localparam int INDEX_W   = 2;
    localparam int TAG_W     = ADDR_W - INDEX_W;
    localparam int N_SETS    = 1 << INDEX_W;
    localparam int MEM_WORDS = 1 << ADDR_W;
    localparam int CNT_W     = 16;

    // Same word seen flat by memory or split by the line store
    typedef union packed {
        logic [ADDR_W-1:0] raw;
        struct packed {
            logic [TAG_W-1:0]   tag;
            logic [INDEX_W-1:0] index;
        } fld;
    } cache_addr_u;

endpackage

/* design/coherence_pkg.sv */
/*
 * MESI coherence encodings
 * Line states held per cache line and the commands a coherency unit
 * places on the shared bus
 */
package coherence_pkg;

    // Line state
    typedef enum logic [1:0] {
        MODIFIED,   // Only copy, dirty
        EXCLUSIVE,  // Only copy, clean
        SHARED,     // Clean, may exist elsewhere
        INVALID
    } mesi_t;

    // Bus transaction kind
    typedef enum logic [1:0] {
        BUS_RD,     // Read miss
        BUS_RDX,    // Write miss or S to M upgrade
        BUS_WB      // Dirty line eviction
    } bus_cmd_t;

endpackage

/* design/coherency_unit.sv */
/*
 * Per-CPU coherency unit
 * Direct-mapped MESI line store, local hit path, writeback/fill FSM
 * and a same-cycle snoop responder
 */
`timescale 1ns/1ps

module coherency_unit (
    input  logic                              CLK,
    input  logic                              nRST,
    input  logic                              ren,
    input  logic                              wen,
    input  cache_geom_pkg::cache_addr_u       addr,
    input  logic [cache_geom_pkg::DATA_W-1:0] wdata,
    output logic [cache_geom_pkg::DATA_W-1:0] rdata,
    output logic                              busy,
    snoop_bus_if.unit                         bus
);

    logic [cache_geom_pkg::TAG_W-1:0]  tag_q  [cache_geom_pkg::N_SETS];
    logic [cache_geom_pkg::DATA_W-1:0] data_q [cache_geom_pkg::N_SETS];
    coherence_pkg::mesi_t              mesi_q [cache_geom_pkg::N_SETS];

    enum logic [1:0] {IDLE, WRITEBACK, FILL} state_q, state_d;

    logic [cache_geom_pkg::INDEX_W-1:0] idx;
    logic [cache_geom_pkg::INDEX_W-1:0] snp_idx;
    logic tag_match;
    logic line_hit;
    logic snoop_clash;
    logic cpu_hit;
    logic write_ok;
    logic victim_dirty;
    logic cpu_write_hit;
    logic snp_match;

    assign idx     = addr.fld.index;
    assign snp_idx = bus.snoop_addr.fld.index;

    assign tag_match    = tag_q[idx] == addr.fld.tag;
    assign line_hit     = tag_match && mesi_q[idx] != coherence_pkg::INVALID;
    // A snoop to the same set owns the line this cycle, so the CPU waits one cycle
    assign snoop_clash  = bus.snoop_valid && snp_idx == idx;
    assign cpu_hit      = line_hit && !snoop_clash;
    assign write_ok     = cpu_hit && (mesi_q[idx] == coherence_pkg::MODIFIED ||
                                      mesi_q[idx] == coherence_pkg::EXCLUSIVE);
    assign victim_dirty = !line_hit && mesi_q[idx] == coherence_pkg::MODIFIED;
    assign cpu_write_hit = state_q == IDLE && wen && write_ok;

    // Snoop reply straight from the line store
    assign snp_match = tag_q[snp_idx] == bus.snoop_addr.fld.tag &&
                       mesi_q[snp_idx] != coherence_pkg::INVALID;
    assign bus.snoop_hit   = bus.snoop_valid && snp_match;
    assign bus.snoop_dirty = bus.snoop_valid && snp_match &&
                             mesi_q[snp_idx] == coherence_pkg::MODIFIED;
    assign bus.snoop_data  = data_q[snp_idx];

    assign bus.req = state_q != IDLE;

    always_comb begin
        if (state_q == WRITEBACK) begin
            bus.cmd      = coherence_pkg::BUS_WB;
            bus.addr.raw = {tag_q[idx], idx};   // Victim address
            bus.wdata    = data_q[idx];
        end else begin
            bus.cmd   = wen ? coherence_pkg::BUS_RDX : coherence_pkg::BUS_RD;
            bus.addr  = addr;
            bus.wdata = wdata;
        end
    end

    always_comb begin
        state_d = state_q;
        busy    = 1'b0;
        rdata   = data_q[idx];
        case (state_q)
            IDLE: begin
                if ((ren || wen) && (wen ? !write_ok : !cpu_hit)) begin
                    busy = 1'b1;
                    if (!snoop_clash) begin
                        state_d = victim_dirty ? WRITEBACK : FILL;
                    end
                end
            end
            WRITEBACK: begin
                busy = 1'b1;
                if (bus.done) begin
                    state_d = FILL;
                end
            end
            FILL: begin
                busy  = !bus.done;
                rdata = bus.rdata;      // Fill data goes to the CPU as it arrives
                if (bus.done) begin
                    state_d = IDLE;
                end
            end
            default: state_d = IDLE;
        endcase
    end

    always_ff @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            state_q <= IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    // Line states, snoop update last so it wins
    always_ff @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            for (int i = 0; i < cache_geom_pkg::N_SETS; i++) begin
                mesi_q[i] <= coherence_pkg::INVALID;
            end
        end else begin
            if (cpu_write_hit) begin
                mesi_q[idx] <= coherence_pkg::MODIFIED;     // E to M is silent
            end
            if (state_q == WRITEBACK && bus.done) begin
                mesi_q[idx] <= coherence_pkg::INVALID;      // Victim now in memory
            end
            if (state_q == FILL && bus.done) begin
                if (wen) begin
                    mesi_q[idx] <= coherence_pkg::MODIFIED;
                end else begin
                    mesi_q[idx] <= bus.exclusive ? coherence_pkg::EXCLUSIVE
                                                 : coherence_pkg::SHARED;
                end
            end
            if (bus.snoop_hit) begin
                mesi_q[snp_idx] <= bus.snoop_inv ? coherence_pkg::INVALID
                                                 : coherence_pkg::SHARED;
            end
        end
    end

    always_ff @(posedge CLK) begin
        if (cpu_write_hit) begin
            data_q[idx] <= wdata;
        end
        if (state_q == FILL && bus.done) begin
            tag_q[idx]  <= addr.fld.tag;
            data_q[idx] <= wen ? wdata : bus.rdata;
        end
    end

    // Fill and snoop updates never meet on one edge
    a_done_no_snoop: assert property (@(posedge CLK) disable iff (!nRST)
        bus.done |-> !bus.snoop_valid)
        else $error("done and snoop_valid in the same cycle");

    a_done_needs_req: assert property (@(posedge CLK) disable iff (!nRST)
        bus.done |-> bus.req)
        else $error("done without a pending request");

endmodule

/* design/mesi_pair_top.sv */
/*
 * Two-CPU MESI subsystem
 * Two coherency units sharing one bus controller and memory
 */
`timescale 1ns/1ps

module mesi_pair_top (
    input  logic                              CLK,
    input  logic                              nRST,
    input  logic                              ren_0,
    input  logic                              wen_0,
    input  logic [cache_geom_pkg::ADDR_W-1:0] addr_0,
    input  logic [cache_geom_pkg::DATA_W-1:0] wdata_0,
    output logic [cache_geom_pkg::DATA_W-1:0] rdata_0,
    output logic                              busy_0,
    input  logic                              ren_1,
    input  logic                              wen_1,
    input  logic [cache_geom_pkg::ADDR_W-1:0] addr_1,
    input  logic [cache_geom_pkg::DATA_W-1:0] wdata_1,
    output logic [cache_geom_pkg::DATA_W-1:0] rdata_1,
    output logic                              busy_1,
    output logic [cache_geom_pkg::CNT_W-1:0]  fills_exclusive,
    output logic [cache_geom_pkg::CNT_W-1:0]  fills_shared,
    output logic [cache_geom_pkg::CNT_W-1:0]  snoop_invalidations,
    output logic [cache_geom_pkg::CNT_W-1:0]  snoop_downgrades,
    output logic [cache_geom_pkg::CNT_W-1:0]  writebacks
);

    snoop_bus_if bus0 ();
    snoop_bus_if bus1 ();

    coherency_unit u_cpu0 (
        .CLK   (CLK),
        .nRST  (nRST),
        .ren   (ren_0),
        .wen   (wen_0),
        .addr  (addr_0),
        .wdata (wdata_0),
        .rdata (rdata_0),
        .busy  (busy_0),
        .bus   (bus0.unit)
    );

    coherency_unit u_cpu1 (
        .CLK   (CLK),
        .nRST  (nRST),
        .ren   (ren_1),
        .wen   (wen_1),
        .addr  (addr_1),
        .wdata (wdata_1),
        .rdata (rdata_1),
        .busy  (busy_1),
        .bus   (bus1.unit)
    );

    bus_controller u_bus (
        .CLK                 (CLK),
        .nRST                (nRST),
        .port0               (bus0.ctrl),
        .port1               (bus1.ctrl),
        .fills_exclusive     (fills_exclusive),
        .fills_shared        (fills_shared),
        .snoop_invalidations (snoop_invalidations),
        .snoop_downgrades    (snoop_downgrades),
        .writebacks          (writebacks)
    );

endmodule

/* design/snoop_bus_if.sv */
/*
 * Coherency unit to bus controller link
 * Carries one unit's bus request and its snoop channel
 */
`timescale 1ns/1ps

interface snoop_bus_if;

    logic                                req;         // Held until done
    coherence_pkg::bus_cmd_t             cmd;
    cache_geom_pkg::cache_addr_u         addr;
    logic [cache_geom_pkg::DATA_W-1:0]   wdata;
    logic                                done;        // One cycle pulse
    logic [cache_geom_pkg::DATA_W-1:0]   rdata;
    logic                                exclusive;   // Valid with done

    logic                                snoop_valid; // One cycle pulse
    cache_geom_pkg::cache_addr_u         snoop_addr;
    logic                                snoop_inv;   // Set for BUS_RDX
    logic                                snoop_hit;
    logic                                snoop_dirty;
    logic [cache_geom_pkg::DATA_W-1:0]   snoop_data;

    modport unit (
        output req, cmd, addr, wdata, snoop_hit, snoop_dirty, snoop_data,
        input  done, rdata, exclusive, snoop_valid, snoop_addr, snoop_inv
    );

    modport ctrl (
        input  req, cmd, addr, wdata, snoop_hit, snoop_dirty, snoop_data,
        output done, rdata, exclusive, snoop_valid, snoop_addr, snoop_inv
    );

endinterface

/* sim/mesi_pair_tb.sv */
/*
 * Testbench for the two-CPU MESI subsystem
 * Replays the access list from the data file, checks read data and event counters
 */
`timescale 1ns/1ps

module mesi_pair_tb;

    localparam int HALF_PERIOD    = 10;
    localparam int TIMEOUT_CYCLES = 50;

    logic                                    CLK;
    logic                                    nRST;
    logic                                    ren_0, wen_0, ren_1, wen_1;
    logic [cache_geom_pkg::ADDR_W-1:0]       addr_0, addr_1;
    logic [cache_geom_pkg::DATA_W-1:0]       wdata_0, wdata_1;
    logic [cache_geom_pkg::DATA_W-1:0]       rdata_0, rdata_1;
    logic                                    busy_0, busy_1;
    logic [cache_geom_pkg::CNT_W-1:0]        fills_exclusive, fills_shared;
    logic [cache_geom_pkg::CNT_W-1:0]        snoop_invalidations, snoop_downgrades;
    logic [cache_geom_pkg::CNT_W-1:0]        writebacks;

    // Accesses collected from the file, started together
    logic                                    act [2];
    logic                                    op_w [2];
    logic [cache_geom_pkg::ADDR_W-1:0]       op_addr [2];
    logic [cache_geom_pkg::DATA_W-1:0]       op_data [2];
    int                                      mismatches;
    int                                      failures;

    mesi_pair_top dut (
        .CLK (CLK), .nRST (nRST),
        .ren_0 (ren_0), .wen_0 (wen_0), .addr_0 (addr_0), .wdata_0 (wdata_0),
        .rdata_0 (rdata_0), .busy_0 (busy_0),
        .ren_1 (ren_1), .wen_1 (wen_1), .addr_1 (addr_1), .wdata_1 (wdata_1),
        .rdata_1 (rdata_1), .busy_1 (busy_1),
        .fills_exclusive (fills_exclusive), .fills_shared (fills_shared),
        .snoop_invalidations (snoop_invalidations),
        .snoop_downgrades (snoop_downgrades), .writebacks (writebacks)
    );

    initial begin
        CLK = 1'b0;
        forever #HALF_PERIOD CLK = ~CLK;
    end

    task automatic drive_cpu(input int c, input logic r, input logic w,
                             input logic [7:0] a, input logic [31:0] d);
        if (c == 0) begin
            ren_0   = r;
            wen_0   = w;
            addr_0  = a;
            wdata_0 = d;
        end else begin
            ren_1   = r;
            wen_1   = w;
            addr_1  = a;
            wdata_1 = d;
        end
    endtask

    function automatic logic busy_of(input int c);
        return (c == 0) ? busy_0 : busy_1;
    endfunction

    function automatic logic [31:0] rdata_of(input int c);
        return (c == 0) ? rdata_0 : rdata_1;
    endfunction

    task automatic load_op(input int c, input logic [7:0] op,
                           input logic [7:0] a, input logic [31:0] d);
        act[c]     = 1'b1;
        op_w[c]    = (op == "W");
        op_addr[c] = a;
        op_data[c] = d;
    endtask

    // Start the collected accesses on a falling edge and hold each until busy drops
    task automatic run_pending();
        int cycles;
        int gap;
        bit waiting [2];
        if (!(act[0] || act[1])) return;
        gap = $urandom % 4;
        repeat (gap) @(negedge CLK);
        for (int c = 0; c < 2; c++) begin
            waiting[c] = act[c];
            if (act[c]) drive_cpu(c, !op_w[c], op_w[c], op_addr[c], op_data[c]);
        end
        cycles = 0;
        while ((waiting[0] || waiting[1]) && cycles < TIMEOUT_CYCLES) begin
            #(HALF_PERIOD - 1);                         // Just before the rising edge
            for (int c = 0; c < 2; c++) begin
                if (waiting[c] && !busy_of(c)) begin
                    if (!op_w[c] && rdata_of(c) !== op_data[c]) begin
                        $display("mismatch rdata_%0d addr %h: got %h expected %h",
                                 c, op_addr[c], rdata_of(c), op_data[c]);
                        mismatches++;
                    end
                    waiting[c] = 1'b0;
                end
            end
            @(negedge CLK);
            for (int c = 0; c < 2; c++) begin
                if (act[c] && !waiting[c]) begin
                    drive_cpu(c, 1'b0, 1'b0, op_addr[c], op_data[c]);
                    act[c] = 1'b0;
                end
            end
            cycles++;
        end
        if (waiting[0] || waiting[1]) begin
            $display("CPU access did not complete within %0d cycles", TIMEOUT_CYCLES);
            failures++;
        end
    endtask

    task automatic check_count(input string name, input logic [15:0] got,
                               input logic [15:0] exp);
        if (got !== exp) begin
            $display("mismatch %s: got %h expected %h", name, got, exp);
            mismatches++;
        end
    endtask

    initial begin
        int          fd;
        int          n;
        int          cpu;
        int          seed;
        bit          have_totals;
        string       line;
        logic [7:0]  kind;
        logic [7:0]  op;
        logic [7:0]  a;
        logic [31:0] d;
        logic [15:0] e0, e1, e2, e3, e4;
        seed = 17;
        void'($urandom(seed));
        nRST        = 1'b0;
        mismatches  = 0;
        failures    = 0;
        have_totals = 1'b0;
        act[0]      = 1'b0;
        act[1]      = 1'b0;
        drive_cpu(0, 1'b0, 1'b0, 8'h00, 32'h0);
        drive_cpu(1, 1'b0, 1'b0, 8'h00, 32'h0);
        repeat (10) @(negedge CLK);
        nRST = 1'b1;

        fd = $fopen("sim/mesi_testdata.txt", "r");
        if (fd == 0) begin
            $display("Could not open the test data file");
            failures++;
        end else begin
            while (failures == 0 && $fgets(line, fd) > 0) begin
                n = $sscanf(line, "%s", kind);
                if (n < 1 || kind == "#") begin
                    // Blank or comment line
                end else if (kind == "T") begin
                    run_pending();
                    n = $sscanf(line, "T %h %h %h %h %h", e0, e1, e2, e3, e4);
                    check_count("fills_exclusive", fills_exclusive, e0);
                    check_count("fills_shared", fills_shared, e1);
                    check_count("snoop_invalidations", snoop_invalidations, e2);
                    check_count("snoop_downgrades", snoop_downgrades, e3);
                    check_count("writebacks", writebacks, e4);
                    have_totals = 1'b1;
                end else begin
                    if (kind == "&") begin
                        n = $sscanf(line, "& %d %s %h %h", cpu, op, a, d);
                    end else begin
                        run_pending();
                        n = $sscanf(line, "%d %s %h %h", cpu, op, a, d);
                    end
                    if (n == 4 && (cpu == 0 || cpu == 1)) load_op(cpu, op, a, d);
                    else begin
                        $display("Malformed access line in the test data file");
                        failures++;
                    end
                end
            end
            run_pending();
            $fclose(fd);
            if (!have_totals) begin
                $display("Test data file has no counter line");
                failures++;
            end
        end

        $display("Errors: %0d mismatches, %0d other failures", mismatches, failures);
        if (mismatches == 0 && failures == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

/* sim/mesi_testdata.txt */
# cpu op addr data: one access, data is write data for W and expected read data for R
# A leading & starts the access in the same cycle as the line above
# Final line: T fills_exclusive fills_shared snoop_invalidations snoop_downgrades writebacks
# Exclusive fill, then silent E to M write
0 R 10 00000000
0 W 10 11111111
0 R 10 11111111
# CPU1 reads a line CPU0 holds modified
1 R 10 11111111
# Write to a shared line invalidates the other copy
1 W 10 22222222
0 R 10 22222222
# Dirty eviction on the same index
0 W 21 33333333
0 W 25 44444444
1 R 21 33333333
# Misses started in the same cycle
0 R 32 00000000
& 1 R 32 00000000
0 W 43 55555555
& 1 W 47 66666666
1 R 43 55555555
0 R 47 66666666
T 0004 0004 0001 0004 0002

/* verilog.f */
design/coherence_pkg.sv
design/cache_geom_pkg.sv
design/snoop_bus_if.sv
design/coherency_unit.sv
design/bus_controller.sv
design/mesi_pair_top.sv
sim/mesi_pair_tb.sv
